//--- src/cache_pkg.sv
package cache_pkg;

    // Address split for a 2-way, 4 KB per way cache.
    localparam int ADDR_WIDTH     = 32;
    localparam int NUM_WAY        = 2;
    localparam int BYTES_PER_LINE = 16;
    localparam int NUM_LINE       = 256;

    localparam int OFFSET_WIDTH   = $clog2(BYTES_PER_LINE);
    localparam int INDEX_WIDTH    = $clog2(NUM_LINE);
    localparam int TAG_WIDTH      = ADDR_WIDTH - OFFSET_WIDTH - INDEX_WIDTH;
    localparam int WORDS_PER_LINE = BYTES_PER_LINE / 4;
    localparam int LINE_WIDTH     = BYTES_PER_LINE * 8;

    // Backing store, 16 KB of 32-bit words.
    localparam int MEM_WORDS      = 4096;
    localparam int MEM_LATENCY    = 3;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        DIRTY_MISS,
        REPLACE,
        REFILL
    } cache_state_e;

endpackage

//--- src/bram.sv
`timescale 1ns/1ps

module bram #(
    parameter int DEPTH = 256,
    parameter int WIDTH = 32,
    localparam int WE_WIDTH = (WIDTH % 8 == 0) ? WIDTH / 8 : 1
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic [WIDTH-1:0]         din,
    input  logic [WE_WIDTH-1:0]      we,
    output logic [WIDTH-1:0]         dout
);

    logic [WIDTH-1:0] mem [DEPTH];

    if (WIDTH % 8 == 0) begin : g_byte_write
        always_ff @(posedge clk) begin
            for (int b = 0; b < WE_WIDTH; b++) begin
                if (we[b]) begin
                    mem[addr][b*8 +: 8] <= din[b*8 +: 8];
                end
            end
        end
    end else begin : g_word_write
        // Odd widths have no byte lanes, so one enable covers the word.
        always_ff @(posedge clk) begin
            if (we[0]) begin
                mem[addr] <= din;
            end
        end
    end

    // Read-first, the old contents come out during a write.
    always_ff @(posedge clk) begin
        dout <= mem[addr];
    end

endmodule

//--- src/mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if import cache_pkg::*; ();

    // Line read channel.
    logic                  rd_req;
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic                  rd_rdy;
    logic                  ret_valid;
    logic                  ret_last;
    logic [31:0]           ret_data;

    // Line write-back channel.
    logic                  wr_req;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [LINE_WIDTH-1:0] wr_data;
    logic                  wr_rdy;

    modport cache (
        output rd_req, rd_addr, wr_req, wr_addr, wr_data,
        input  rd_rdy, ret_valid, ret_last, ret_data, wr_rdy
    );

    modport memory (
        input  rd_req, rd_addr, wr_req, wr_addr, wr_data,
        output rd_rdy, ret_valid, ret_last, ret_data, wr_rdy
    );

endinterface

//--- src/cache_way_if.sv
`timescale 1ns/1ps

interface cache_way_if import cache_pkg::*; ();

    logic [INDEX_WIDTH-1:0]                addr;
    logic                                  tag_we;
    logic [TAG_WIDTH-1:0]                  tag_din;
    logic                                  valid_din;
    logic                                  dirty_we;
    logic                                  dirty_din;
    logic [WORDS_PER_LINE-1:0][3:0]        bank_we;
    logic [WORDS_PER_LINE-1:0][31:0]       bank_din;

    logic [TAG_WIDTH-1:0]                  tag_dout;
    logic                                  valid_dout;
    logic                                  dirty_dout;
    logic [WORDS_PER_LINE-1:0][31:0]       bank_dout;

    modport ctrl (
        output addr, tag_we, tag_din, valid_din, dirty_we, dirty_din, bank_we, bank_din,
        input  tag_dout, valid_dout, dirty_dout, bank_dout
    );

    modport way (
        input  addr, tag_we, tag_din, valid_din, dirty_we, dirty_din, bank_we, bank_din,
        output tag_dout, valid_dout, dirty_dout, bank_dout
    );

endinterface

//--- src/cache_way.sv
`timescale 1ns/1ps

module cache_way import cache_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    cache_way_if.way way_bus
);

    logic [TAG_WIDTH:0]  tag_q;
    logic [NUM_LINE-1:0] dirty;

    // Tag and valid share one RAM word, valid in bit 0.
    bram #(
        .DEPTH (NUM_LINE),
        .WIDTH (TAG_WIDTH + 1)
    ) u_tag (
        .clk  (clk),
        .addr (way_bus.addr),
        .din  ({way_bus.tag_din, way_bus.valid_din}),
        .we   (way_bus.tag_we),
        .dout (tag_q)
    );

    assign way_bus.tag_dout   = tag_q[TAG_WIDTH:1];
    assign way_bus.valid_dout = tag_q[0];

    // Dirty bits sit in flops so the victim check sees them in the same cycle.
    always_ff @(posedge clk) begin
        if (reset) begin
            dirty <= '0;
        end else if (way_bus.dirty_we) begin
            dirty[way_bus.addr] <= way_bus.dirty_din;
        end
    end

    assign way_bus.dirty_dout = dirty[way_bus.addr];

    for (genvar j = 0; j < WORDS_PER_LINE; j++) begin : g_bank
        bram #(
            .DEPTH (NUM_LINE),
            .WIDTH (32)
        ) u_bank (
            .clk  (clk),
            .addr (way_bus.addr),
            .din  (way_bus.bank_din[j]),
            .we   (way_bus.bank_we[j]),
            .dout (way_bus.bank_dout[j])
        );
    end

endmodule

//--- src/cache.sv
`timescale 1ns/1ps

module cache import cache_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  valid,
    input  logic                  write,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [3:0]            wstrb,
    input  logic [31:0]           wdata,
    output logic                  addr_ok,
    output logic                  data_ok,
    output logic [31:0]           rdata,
    mem_bus_if.cache              mem_bus
);

    cache_state_e state;
    cache_state_e state_next;

    logic [TAG_WIDTH-1:0]              req_tag;
    logic [INDEX_WIDTH-1:0]            req_index;
    logic [$clog2(WORDS_PER_LINE)-1:0] req_word;
    logic                              req_write;
    logic [3:0]                        req_wstrb;
    logic [31:0]                       req_wdata;

    logic                              sweep_busy;
    logic [INDEX_WIDTH-1:0]            sweep_idx;
    logic [NUM_LINE-1:0]               repl;
    logic [$clog2(NUM_WAY)-1:0]        victim;
    logic [$clog2(WORDS_PER_LINE)-1:0] refill_word;
    logic [31:0]                       refill_rdata;
    logic [31:0]                       refill_merged;
    logic                              refill_done;

    logic [NUM_WAY-1:0]                hit_way;
    logic [NUM_WAY-1:0]                way_dirty;
    logic [31:0]                       way_word [NUM_WAY];
    logic [TAG_WIDTH-1:0]              way_tag [NUM_WAY];
    logic [LINE_WIDTH-1:0]             way_line [NUM_WAY];
    logic [31:0]                       hit_data;
    logic                              hit;
    logic                              accept;
    logic                              write_hit;
    logic                              refill_beat;
    logic                              refill_last;
    logic [INDEX_WIDTH-1:0]            way_addr;
    logic [31:0]                       bank_word;

    cache_way_if way_bus [NUM_WAY] ();

    assign accept      = valid && addr_ok;
    assign hit         = |hit_way;
    assign write_hit   = (state == LOOKUP) && hit && req_write;
    assign refill_beat = (state == REFILL) && mem_bus.ret_valid;
    assign refill_last = refill_beat && mem_bus.ret_last;
    assign victim      = repl[req_index];

    always_ff @(posedge clk) begin
        if (accept) begin
            req_tag   <= addr[ADDR_WIDTH-1 -: TAG_WIDTH];
            req_index <= addr[OFFSET_WIDTH +: INDEX_WIDTH];
            req_word  <= addr[OFFSET_WIDTH-1:2];
            req_write <= write;
            req_wstrb <= wstrb;
            req_wdata <= wdata;
        end
    end

    // After reset every set is walked once to clear the valid bits.
    always_ff @(posedge clk) begin
        if (reset) begin
            sweep_busy <= 1'b1;
            sweep_idx  <= '0;
        end else if (sweep_busy) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (&sweep_idx) begin
                sweep_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            repl        <= '0;
            refill_word <= '0;
            refill_done <= 1'b0;
        end else begin
            state       <= state_next;
            refill_done <= refill_last;
            if (refill_last) begin
                repl[req_index] <= ~repl[req_index];
            end
            if (state != REFILL) begin
                refill_word <= '0;
            end else if (mem_bus.ret_valid) begin
                refill_word <= refill_word + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (refill_beat && (refill_word == req_word)) begin
            refill_rdata <= mem_bus.ret_data;
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            IDLE: begin
                if (accept) state_next = LOOKUP;
            end
            LOOKUP: begin
                if (hit) begin
                    state_next = accept ? LOOKUP : IDLE;
                end else if (way_dirty[victim]) begin
                    state_next = DIRTY_MISS;
                end else begin
                    state_next = MISS;
                end
            end
            MISS: begin
                if (mem_bus.rd_rdy) state_next = REFILL;
            end
            DIRTY_MISS: begin
                if (mem_bus.wr_rdy) state_next = REPLACE;
            end
            REPLACE: begin
                if (mem_bus.rd_rdy) state_next = REFILL;
            end
            REFILL: begin
                if (refill_last) state_next = IDLE;
            end
            default: state_next = IDLE;
        endcase
    end

    // A read hit may take the next request while its own data goes out.
    assign addr_ok = !sweep_busy
                     && ((state == IDLE) || ((state == LOOKUP) && hit && !req_write));
    assign data_ok = ((state == LOOKUP) && hit) || refill_done;
    assign rdata   = (state == LOOKUP) ? hit_data : refill_rdata;

    always_comb begin
        hit_data = '0;
        for (int i = 0; i < NUM_WAY; i++) begin
            hit_data = hit_data | ({32{hit_way[i]}} & way_word[i]);
        end
    end

    // Store data replaces the strobed bytes of the word being refilled.
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            if (req_write && (refill_word == req_word) && req_wstrb[b]) begin
                refill_merged[b*8 +: 8] = req_wdata[b*8 +: 8];
            end else begin
                refill_merged[b*8 +: 8] = mem_bus.ret_data[b*8 +: 8];
            end
        end
    end

    assign way_addr  = sweep_busy ? sweep_idx
                     : (addr_ok ? addr[OFFSET_WIDTH +: INDEX_WIDTH] : req_index);
    assign bank_word = (state == REFILL) ? refill_merged : req_wdata;

    assign mem_bus.rd_req  = (state == MISS) || (state == REPLACE);
    assign mem_bus.rd_addr = {req_tag, req_index, {OFFSET_WIDTH{1'b0}}};
    // The victim RAM outputs stay put while the set index is held.
    assign mem_bus.wr_req  = (state == DIRTY_MISS);
    assign mem_bus.wr_addr = {way_tag[victim], req_index, {OFFSET_WIDTH{1'b0}}};
    assign mem_bus.wr_data = way_line[victim];

    for (genvar i = 0; i < NUM_WAY; i++) begin : g_way
        cache_way u_way (
            .clk     (clk),
            .reset   (reset),
            .way_bus (way_bus[i])
        );

        assign way_bus[i].addr      = way_addr;
        assign way_bus[i].tag_we    = sweep_busy || (refill_last && (victim == i));
        assign way_bus[i].tag_din   = req_tag;
        assign way_bus[i].valid_din = !sweep_busy;
        assign way_bus[i].dirty_we  = (write_hit && hit_way[i]) || (refill_last && (victim == i));
        assign way_bus[i].dirty_din = req_write;
        assign way_bus[i].bank_din  = {WORDS_PER_LINE{bank_word}};

        always_comb begin
            way_bus[i].bank_we = '0;
            if (write_hit && hit_way[i]) begin
                way_bus[i].bank_we[req_word] = req_wstrb;
            end else if (refill_beat && (victim == i)) begin
                way_bus[i].bank_we[refill_word] = 4'hf;
            end
        end

        assign hit_way[i]   = way_bus[i].valid_dout && (way_bus[i].tag_dout == req_tag);
        assign way_dirty[i] = way_bus[i].dirty_dout;
        assign way_word[i]  = way_bus[i].bank_dout[req_word];
        assign way_tag[i]   = way_bus[i].tag_dout;
        assign way_line[i]  = way_bus[i].bank_dout;
    end

endmodule

//--- src/main_memory.sv
`timescale 1ns/1ps

module main_memory import cache_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    mem_bus_if.memory  mem_bus
);

    logic [31:0]                                 store [MEM_WORDS];
    logic                                        busy;
    logic [$clog2(MEM_LATENCY)-1:0]              lat_cnt;
    logic [$clog2(WORDS_PER_LINE)-1:0]           word_cnt;
    logic [$clog2(MEM_WORDS)+1-OFFSET_WIDTH:0]   rd_line;
    logic [$clog2(MEM_WORDS)+1-OFFSET_WIDTH:0]   wr_line;

    // Byte address bits above the store size are ignored.
    assign wr_line = mem_bus.wr_addr[$clog2(MEM_WORDS)+1:OFFSET_WIDTH];

    assign mem_bus.rd_rdy    = !busy;
    assign mem_bus.wr_rdy    = !busy;
    assign mem_bus.ret_valid = busy && (lat_cnt == '0);
    assign mem_bus.ret_last  = mem_bus.ret_valid && (&word_cnt);
    assign mem_bus.ret_data  = store[int'(rd_line) * WORDS_PER_LINE + int'(word_cnt)];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                store[i] <= 32'(i << 2) ^ 32'hffff_0000;
            end
        end else if (mem_bus.wr_req && mem_bus.wr_rdy) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                store[int'(wr_line) * WORDS_PER_LINE + w] <= mem_bus.wr_data[w*32 +: 32];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_bus.rd_req && mem_bus.rd_rdy) begin
            rd_line <= mem_bus.rd_addr[$clog2(MEM_WORDS)+1:OFFSET_WIDTH];
        end
    end

    // Wait out the latency, then send one word per cycle.
    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            lat_cnt  <= '0;
            word_cnt <= '0;
        end else if (!busy) begin
            if (mem_bus.rd_req) begin
                busy     <= 1'b1;
                lat_cnt  <= ($clog2(MEM_LATENCY))'(MEM_LATENCY - 1);
                word_cnt <= '0;
            end
        end else if (lat_cnt != '0) begin
            lat_cnt <= lat_cnt - 1'b1;
        end else begin
            word_cnt <= word_cnt + 1'b1;
            if (&word_cnt) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

//--- src/cache_top.sv
`timescale 1ns/1ps

module cache_top import cache_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  valid,
    input  logic                  write,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [3:0]            wstrb,
    input  logic [31:0]           wdata,
    output logic                  addr_ok,
    output logic                  data_ok,
    output logic [31:0]           rdata
);

    mem_bus_if mem_bus ();

    cache u_cache (
        .clk     (clk),
        .reset   (reset),
        .valid   (valid),
        .write   (write),
        .addr    (addr),
        .wstrb   (wstrb),
        .wdata   (wdata),
        .addr_ok (addr_ok),
        .data_ok (data_ok),
        .rdata   (rdata),
        .mem_bus (mem_bus)
    );

    main_memory u_main_memory (
        .clk     (clk),
        .reset   (reset),
        .mem_bus (mem_bus)
    );

endmodule

//--- verif/cache_tb.sv
`timescale 1ns/1ps

module cache_tb import cache_pkg::*; ();

    localparam int RESET_CYCLES    = 16;
    localparam int NUM_REQUESTS    = 422;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_LINE + 200 * NUM_REQUESTS;
    localparam logic [ADDR_WIDTH-1:0] LINE_A = 32'h0000_1230;

    logic                  clk;
    logic                  reset;
    logic                  valid;
    logic                  write;
    logic [ADDR_WIDTH-1:0] addr;
    logic [3:0]            wstrb;
    logic [31:0]           wdata;
    logic                  addr_ok;
    logic                  data_ok;
    logic [31:0]           rdata;

    int unsigned cycle_cnt       = 0;
    int unsigned accepted        = 0;
    int unsigned answered        = 0;
    int unsigned issued          = 0;
    int unsigned last_latency    = 0;
    int unsigned last_ok_cycle   = 0;
    int unsigned ok_streak       = 0;
    int          mismatch_errors = 0;
    int          protocol_errors = 0;
    integer      seed;
    logic        in_quiet;

    // Reference memory plus the expected responses of requests still in flight.
    logic [31:0]           model [MEM_WORDS];
    logic [31:0]           exp_q [$];
    logic [ADDR_WIDTH-1:0] addr_q [$];
    logic                  read_q [$];
    int unsigned           cycle_q [$];

    cache_top DUT (
        .clk     (clk),
        .reset   (reset),
        .valid   (valid),
        .write   (write),
        .addr    (addr),
        .wstrb   (wstrb),
        .wdata   (wdata),
        .addr_ok (addr_ok),
        .data_ok (data_ok),
        .rdata   (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Reset plus the 256-cycle valid-clear sweep.
    assign in_quiet = (cycle_cnt >= 1) && (cycle_cnt < RESET_CYCLES + NUM_LINE);

    quiet_during_sweep: assert property (@(posedge clk) in_quiet |-> (!addr_ok && !data_ok))
        else begin
            protocol_errors++;
            $display("Handshake output high at %0t during reset or the valid sweep", $time);
        end

    memory_quiet_during_sweep: assert property (@(posedge clk) in_quiet |->
                                                (!DUT.mem_bus.rd_req && !DUT.mem_bus.wr_req))
        else begin
            protocol_errors++;
            $display("Memory request high at %0t during reset or the valid sweep", $time);
        end

    handshake_known: assert property (@(posedge clk) (cycle_cnt >= 1) |->
                                      !$isunknown({addr_ok, data_ok}))
        else begin
            protocol_errors++;
            $display("addr_ok or data_ok is unknown at %0t", $time);
        end

    store_blocks_next: assert property (@(posedge clk) (valid && addr_ok && write) |=> !addr_ok)
        else begin
            protocol_errors++;
            $display("addr_ok high at %0t in the cycle after a store was accepted", $time);
        end

    data_ok_needs_request: assert property (@(posedge clk) data_ok |-> (accepted != answered))
        else begin
            protocol_errors++;
            $display("data_ok at %0t with no request outstanding", $time);
        end

    function automatic logic [31:0] pattern_word(input int unsigned index);
        logic [31:0] byte_addr;
        byte_addr = 32'(index * 4);
        return {~byte_addr[31:16], byte_addr[15:0]};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    // Requests finish in order, so the model is updated when a request is accepted.
    always @(posedge clk) begin : monitor
        logic [$clog2(MEM_WORDS)-1:0] widx;
        logic [31:0]                  expected;
        logic [ADDR_WIDTH-1:0]        req_addr;
        logic                         was_read;
        int unsigned                  acc_cycle;
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                model[i] = pattern_word(i);
            end
        end else begin
            if (data_ok && (exp_q.size() > 0)) begin
                expected  = exp_q.pop_front();
                req_addr  = addr_q.pop_front();
                was_read  = read_q.pop_front();
                acc_cycle = cycle_q.pop_front();
                last_latency  <= cycle_cnt - acc_cycle;
                ok_streak     <= (cycle_cnt == last_ok_cycle + 1) ? ok_streak + 1 : 1;
                last_ok_cycle <= cycle_cnt;
                answered      <= answered + 1;
                if (was_read) begin
                    rdata_matches: assert (rdata === expected) else begin
                        mismatch_errors++;
                        $display("MISMATCH t=%0t rdata addr=%08h expected=%08h actual=%08h",
                                 $time, req_addr, expected, rdata);
                    end
                end
            end
            if (valid && addr_ok) begin
                widx = addr[$clog2(MEM_WORDS)+1:2];
                if (write) begin
                    model[widx] = merge_bytes(model[widx], wdata, wstrb);
                end
                exp_q.push_back(model[widx]);
                addr_q.push_back(addr);
                read_q.push_back(!write);
                cycle_q.push_back(cycle_cnt);
                accepted <= accepted + 1;
            end
        end
    end

    // Called on a rising edge and returns on the edge where the request is accepted.
    task automatic send(input logic wr, input logic [ADDR_WIDTH-1:0] a,
                        input logic [3:0] strb, input logic [31:0] d);
        valid <= 1'b1;
        write <= wr;
        addr  <= a;
        wstrb <= strb;
        wdata <= d;
        @(posedge clk);
        while (!addr_ok) begin
            @(posedge clk);
        end
        issued++;
    endtask

    task automatic read_word(input logic [ADDR_WIDTH-1:0] a);
        send(1'b0, a, 4'h0, 32'h0);
    endtask

    task automatic write_word(input logic [ADDR_WIDTH-1:0] a, input logic [3:0] strb,
                              input logic [31:0] d);
        send(1'b1, a, strb, d);
    endtask

    task automatic drain();
        valid <= 1'b0;
        while (answered != issued) begin
            @(posedge clk);
        end
    endtask

    task automatic check_hit_latency(input logic [ADDR_WIDTH-1:0] a);
        hit_latency: assert (last_latency == 1) else begin
            protocol_errors++;
            $display("Read hit to %08h at %0t took %0d cycles from addr_ok to data_ok",
                     a, $time, last_latency);
        end
    endtask

    initial begin : stimulus
        logic [31:0]           r;
        logic [ADDR_WIDTH-1:0] a;
        reset = 1'b1;
        valid = 1'b0;
        write = 1'b0;
        addr  = '0;
        wstrb = '0;
        wdata = '0;
        seed  = 32'h3909;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // The first request waits out the sweep with valid held high.
        read_word(32'h0000_0040);
        drain();

        read_word(LINE_A + 4);
        drain();
        read_word(LINE_A + 8);
        drain();
        check_hit_latency(LINE_A + 8);
        read_word(LINE_A + 4);
        drain();
        check_hit_latency(LINE_A + 4);

        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            read_word(LINE_A + 32'(w * 4));
        end
        drain();
        back_to_back: assert (ok_streak == WORDS_PER_LINE) else begin
            protocol_errors++;
            $display("Back-to-back read hits gave only %0d data_ok pulses in a row", ok_streak);
        end

        // Partial stores, first on a cached line and then on a line that misses.
        write_word(LINE_A + 8, 4'b0101, 32'ha5a5_5a5a);
        drain();
        read_word(LINE_A + 8);
        drain();
        write_word(32'h0000_2564, 4'b1010, 32'h1357_9bdf);
        drain();
        read_word(32'h0000_2564);
        read_word(32'h0000_2568);
        drain();

        // Three dirty lines in one set, so the third store must evict a dirty way.
        for (int t = 1; t <= 3; t++) begin
            write_word(32'(t << 12) | 32'h3a4, 4'hf, 32'hc0de_0000 + 32'(t));
        end
        drain();
        for (int t = 1; t <= 3; t++) begin
            read_word(32'(t << 12) | 32'h3a4);
            read_word(32'(t << 12) | 32'h3ac);
        end
        drain();

        // Only four tags fit under the 16 KB backing store.
        for (int n = 0; n < 400; n++) begin
            r = $random(seed);
            a = 32'({r[1:0], r[3:2], 6'h0a, r[5:4], 2'b00});
            if (r[8]) begin
                write_word(a, r[12:9], $random(seed));
            end else begin
                read_word(a);
            end
        end
        drain();

        repeat (4) @(posedge clk);
        $display("Summary: %0d requests, %0d answered, %0d mismatches, %0d protocol errors",
                 issued, answered, mismatch_errors, protocol_errors);
        if ((mismatch_errors == 0) && (protocol_errors == 0) && (answered == issued)) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timed out after %0d cycles with %0d of %0d requests answered",
                 WATCHDOG_CYCLES, answered, issued);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- compile.f
src/cache_pkg.sv
src/bram.sv
src/mem_bus_if.sv
src/cache_way_if.sv
src/cache_way.sv
src/cache.sv
src/main_memory.sv
src/cache_top.sv
verif/cache_tb.sv

//--- Bender.yml
package:
  name: cache

sources:
  - files:
      - src/cache_pkg.sv
      - src/bram.sv
      - src/mem_bus_if.sv
      - src/cache_way_if.sv
      - src/cache_way.sv
      - src/cache.sv
      - src/main_memory.sv
      - src/cache_top.sv
  - target: test
    files:
      - verif/cache_tb.sv
